/* logic/lsu_defs.svh */
// Width, depth and cause code macros for the load/store unit.
// Included by the package and by modules that need a constant directly.

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data path and address width
`define LSU_XLEN 32
`define LSU_BE_W 4

// Transaction ID returned with each result
`define LSU_TID_W 3

// Registers between raw result and top-level result, 0 means direct
`define LSU_PIPE_DEPTH 1

// RISC-V exception cause codes
`define LSU_CAUSE_LD_MISALIGNED 5'd4
`define LSU_CAUSE_ST_MISALIGNED 5'd6

`endif

/* logic/lsu_pkg.sv */
// Types shared by all load/store unit modules.
// Import it inside a module body, use scoped names in port lists.

`include "lsu_defs.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0]  xlen_t;
  typedef logic [`LSU_BE_W-1:0]  be_t;
  typedef logic [`LSU_TID_W-1:0] trans_id_t;
  typedef logic [4:0]            cause_t;

  // Stores carry bit 3 set
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } lsu_op_e;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    REQ       = 2'd1,
    WAIT_DATA = 2'd2
  } lsu_state_e;

  typedef struct packed {
    logic   valid;
    cause_t cause;
    xlen_t  tval;
  } exception_t;

  // Operation as it arrives from issue
  typedef struct packed {
    lsu_op_e   op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     imm;
    trans_id_t trans_id;
  } lsu_req_t;

  // Decoded operation, held by the controller while it runs
  typedef struct packed {
    logic       is_store;
    lsu_op_e    op;
    xlen_t      address;
    be_t        be;
    xlen_t      wdata;
    trans_id_t  trans_id;
    exception_t ex;
  } lsu_ctrl_t;

  typedef struct packed {
    logic       valid;
    trans_id_t  trans_id;
    xlen_t      data;
    exception_t ex;
  } lsu_result_t;

endpackage

/* logic/lsu_agu.sv */
// Address generation for one issued load or store.
// Purely combinational, the controller registers ctrl_o on acceptance.

`include "lsu_defs.svh"
`timescale 1ns/1ps

module lsu_agu (
  input  lsu_pkg::lsu_req_t  op_i,
  output lsu_pkg::lsu_ctrl_t ctrl_o
);
  import lsu_pkg::*;

  logic  is_store;
  logic  is_half;
  logic  is_word;
  logic  misaligned;
  xlen_t address;

  // Size and direction decode
  always_comb begin
    is_store = 1'b0;
    is_half  = 1'b0;
    is_word  = 1'b0;
    case (op_i.op)
      LH, LHU: is_half = 1'b1;
      LW:      is_word = 1'b1;
      SB:      is_store = 1'b1;
      SH: begin
        is_store = 1'b1;
        is_half  = 1'b1;
      end
      SW: begin
        is_store = 1'b1;
        is_word  = 1'b1;
      end
      default: ;
    endcase
  end

  // No translation, the effective address goes straight to memory
  assign address = op_i.operand_a + op_i.imm;

  assign misaligned = (is_half && address[0]) || (is_word && (address[1:0] != 2'b00));

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.is_store = is_store;
    ctrl_o.op       = op_i.op;
    ctrl_o.address  = address;
    ctrl_o.trans_id = op_i.trans_id;
    // Store data moves into the addressed byte lanes
    ctrl_o.wdata    = op_i.operand_b << {address[1:0], 3'b000};
    if (is_word) begin
      ctrl_o.be = 4'b1111;
    end else if (is_half) begin
      ctrl_o.be = 4'b0011 << {address[1], 1'b0};
    end else begin
      ctrl_o.be = 4'b0001 << address[1:0];
    end
    if (misaligned) begin
      ctrl_o.ex.valid = 1'b1;
      ctrl_o.ex.cause = is_store ? `LSU_CAUSE_ST_MISALIGNED : `LSU_CAUSE_LD_MISALIGNED;
      ctrl_o.ex.tval  = address;
    end
  end

endmodule

/* logic/lsu_ctrl_fsm.sv */
// Controller for one outstanding load or store at a time.
// Drives the request/grant memory port and pulses raw load and store results.

`include "lsu_defs.svh"
`timescale 1ns/1ps

module lsu_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 op_valid_i,
  input  lsu_pkg::lsu_ctrl_t   ctrl_i,
  output logic                 lsu_ready_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output lsu_pkg::xlen_t       mem_addr_o,
  output lsu_pkg::be_t         mem_be_o,
  output lsu_pkg::xlen_t       mem_wdata_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  output lsu_pkg::lsu_op_e     ld_op_o,
  output logic [1:0]           ld_offset_o,
  output lsu_pkg::lsu_result_t ld_res_o,
  output lsu_pkg::lsu_result_t st_res_o
);
  import lsu_pkg::*;

  lsu_state_e state_q, state_d;
  lsu_ctrl_t  ctrl_q;
  logic       accept;
  logic       ld_done;
  logic       st_done;
  logic       ld_valid_q;
  logic       st_valid_q;

  assign lsu_ready_o = (state_q == IDLE);
  assign accept      = op_valid_i && lsu_ready_o;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    ld_done = 1'b0;
    st_done = 1'b0;
    case (state_q)
      IDLE: begin
        if (accept) begin
          // Misaligned operations never reach memory
          if (ctrl_i.ex.valid) begin
            ld_done = !ctrl_i.is_store;
            st_done = ctrl_i.is_store;
          end else begin
            state_d = REQ;
          end
        end
      end
      REQ: begin
        if (mem_gnt_i) begin
          if (ctrl_q.is_store) begin
            st_done = 1'b1;
            state_d = IDLE;
          end else begin
            state_d = WAIT_DATA;
          end
        end
      end
      WAIT_DATA: begin
        if (mem_rvalid_i) begin
          ld_done = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      ld_valid_q <= 1'b0;
      st_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      ld_valid_q <= ld_done;
      st_valid_q <= st_done;
    end
  end

  // Held until the next acceptance, which keeps the request fields stable
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ctrl_q <= ctrl_i;
    end
  end

  // ----------------------------------------------------------------------
  // Memory port and results
  // ----------------------------------------------------------------------
  assign mem_req_o   = (state_q == REQ);
  assign mem_we_o    = ctrl_q.is_store;
  assign mem_addr_o  = {ctrl_q.address[`LSU_XLEN-1:2], 2'b00};
  assign mem_be_o    = ctrl_q.be;
  assign mem_wdata_o = ctrl_q.wdata;

  assign ld_op_o     = ctrl_q.op;
  assign ld_offset_o = ctrl_q.address[1:0];

  // Load data is filled in at the top level from the aligner
  assign ld_res_o = '{valid: ld_valid_q, trans_id: ctrl_q.trans_id, data: '0, ex: ctrl_q.ex};
  assign st_res_o = '{valid: st_valid_q, trans_id: ctrl_q.trans_id, data: '0, ex: ctrl_q.ex};

endmodule

/* logic/lsu_load_align.sv */
// Load data aligner: picks the addressed byte, half or word and extends it.
// The result is captured on read-valid to line up with the raw load result.

`timescale 1ns/1ps

module lsu_load_align (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rvalid_i,
  input  lsu_pkg::xlen_t   rdata_i,
  input  lsu_pkg::lsu_op_e op_i,
  input  logic [1:0]       offset_i,
  output lsu_pkg::xlen_t   data_o
);
  import lsu_pkg::*;

  xlen_t shifted;
  xlen_t aligned;

  // Addressed lane moves down to bit 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  always_comb begin
    case (op_i)
      LB:      aligned = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     aligned = {24'h0, shifted[7:0]};
      LH:      aligned = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     aligned = {16'h0, shifted[15:0]};
      default: aligned = rdata_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_o <= '0;
    end else if (rvalid_i) begin
      data_o <= aligned;
    end
  end

endmodule

/* logic/lsu_result_pipe.sv */
// Fixed-latency pipeline for result structs, one per result path.
// DEPTH stages of delay, a depth of zero is a direct connection.

`include "lsu_defs.svh"
`timescale 1ns/1ps

module lsu_result_pipe #(
  parameter int unsigned DEPTH = `LSU_PIPE_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_result_t res_i,
  output lsu_pkg::lsu_result_t res_o
);
  import lsu_pkg::*;

  if (DEPTH == 0) begin : gen_bypass
    assign res_o = res_i;
  end else begin : gen_stages
    lsu_result_t stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= res_i;
        for (int i = 1; i < DEPTH; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign res_o = stage_q[DEPTH-1];
  end

endmodule

/* logic/lsu_top.sv */
// Load/store unit top level for a 32-bit core without address translation.
// Connects the AGU, controller, load aligner and the two result pipes.

`timescale 1ns/1ps

module lsu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 op_valid_i,
  input  lsu_pkg::lsu_req_t    op_i,
  output logic                 lsu_ready_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output lsu_pkg::xlen_t       mem_addr_o,
  output lsu_pkg::be_t         mem_be_o,
  output lsu_pkg::xlen_t       mem_wdata_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  lsu_pkg::xlen_t       mem_rdata_i,
  output lsu_pkg::lsu_result_t load_res_o,
  output lsu_pkg::lsu_result_t store_res_o
);
  import lsu_pkg::*;

  lsu_ctrl_t   ctrl;
  lsu_op_e     ld_op;
  logic [1:0]  ld_offset;
  xlen_t       ld_data;
  lsu_result_t ld_res_raw;
  lsu_result_t ld_res_full;
  lsu_result_t st_res_raw;

  lsu_agu lsu_agu_inst (
    .op_i  (op_i),
    .ctrl_o(ctrl)
  );

  lsu_ctrl_fsm lsu_ctrl_fsm_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_valid_i  (op_valid_i),
    .ctrl_i      (ctrl),
    .lsu_ready_o (lsu_ready_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_be_o    (mem_be_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rvalid_i(mem_rvalid_i),
    .ld_op_o     (ld_op),
    .ld_offset_o (ld_offset),
    .ld_res_o    (ld_res_raw),
    .st_res_o    (st_res_raw)
  );

  lsu_load_align lsu_load_align_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rvalid_i(mem_rvalid_i),
    .rdata_i (mem_rdata_i),
    .op_i    (ld_op),
    .offset_i(ld_offset),
    .data_o  (ld_data)
  );

  // Aligned data joins the raw load result before the pipe
  assign ld_res_full = '{valid: ld_res_raw.valid, trans_id: ld_res_raw.trans_id,
                         data: ld_data, ex: ld_res_raw.ex};

  lsu_result_pipe load_pipe_inst (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .res_i (ld_res_full),
    .res_o (load_res_o)
  );

  lsu_result_pipe store_pipe_inst (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .res_i (st_res_raw),
    .res_o (store_res_o)
  );

endmodule

/* bench/lsu_sva.sv */
// Protocol assertions for the load/store unit, bound to the top level.
// Covers the memory request hold rule, ready while busy and reset state.

`timescale 1ns/1ps

module lsu_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 lsu_ready_o,
  input logic                 mem_req_o,
  input logic                 mem_we_o,
  input lsu_pkg::xlen_t       mem_addr_o,
  input lsu_pkg::be_t         mem_be_o,
  input lsu_pkg::xlen_t       mem_wdata_o,
  input logic                 mem_gnt_i,
  input logic                 mem_rvalid_i,
  input lsu_pkg::lsu_result_t load_res_o,
  input lsu_pkg::lsu_result_t store_res_o
);
  import lsu_pkg::*;

  logic rd_wait_q;

  // Granted load still waiting for its read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_wait_q <= 1'b0;
    end else if (mem_req_o && mem_gnt_i && !mem_we_o) begin
      rd_wait_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      rd_wait_q <= 1'b0;
    end
  end

  // A pending request keeps its fields until granted
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
      && $stable(mem_be_o) && $stable(mem_wdata_o))
    else $error("memory request dropped or changed before its grant");

  ready_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o || rd_wait_q) |-> !lsu_ready_o)
    else $error("unit ready while a memory access is outstanding");

  reset_valid_a: assert property (@(posedge clk_i)
    !rst_ni |-> !load_res_o.valid && !store_res_o.valid)
    else $error("result valid high during reset");

endmodule

bind lsu_top lsu_sva lsu_sva_inst (.*);

/* bench/lsu_checker.sv */
// Result checker: pairs each DUT result with the next pattern line and compares.
// Also counts memory grants per operation and checks the state after reset.

`timescale 1ns/1ps

module lsu_checker #(
  parameter int N_TESTS = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [147:0]         patterns_i [N_TESTS],
  input  lsu_pkg::lsu_result_t load_res_i,
  input  lsu_pkg::lsu_result_t store_res_i,
  input  logic                 lsu_ready_i,
  input  logic                 mem_req_i,
  input  logic                 mem_gnt_i,
  output logic                 done_o,
  output int                   errors_o
);
  import lsu_pkg::*;

  int   idx = 0;
  int   passed = 0;
  int   grants = 0;
  logic reset_checked = 1'b0;

  initial begin
    done_o   = 1'b0;
    errors_o = 0;
  end

  task automatic check_result(input lsu_result_t res, input logic from_store);
    logic [147:0] pat;
    lsu_op_e      op;
    xlen_t        exp_data;
    xlen_t        exp_tval;
    trans_id_t    exp_tid;
    logic         exp_exv;
    cause_t       exp_cause;
    logic         ok;
    int           exp_grants;
    string        name;
    string        exp_str;
    string        act_str;
    if (idx >= N_TESTS) begin
      $display("Unexpected result with trans_id %0d after the last test", res.trans_id);
      errors_o++;
      return;
    end
    pat        = patterns_i[idx];
    op         = lsu_op_e'(pat[147:144]);
    exp_tval   = pat[143:112] + pat[111:80];
    exp_tid    = pat[46:44];
    exp_data   = pat[43:12];
    exp_exv    = pat[8];
    exp_cause  = pat[4:0];
    exp_grants = exp_exv ? 0 : 1;
    name       = $sformatf("test %0d %s", idx, op.name());
    ok = (res.trans_id == exp_tid) && (res.ex.valid == exp_exv);
    if (exp_exv) begin
      ok = ok && (res.ex.cause == exp_cause) && (res.ex.tval == exp_tval);
    end else begin
      ok = ok && (res.data == exp_data);
    end
    if (from_store != op[3]) begin
      $display("FAILED %s: result came out on the wrong result port", name);
      errors_o++;
    end else if (grants != exp_grants) begin
      $display("FAILED %s: expected %0d memory grant(s) but saw %0d", name, exp_grants, grants);
      errors_o++;
    end else if (!ok) begin
      exp_str = $sformatf("tid %0d data %h ex %0b cause %0d tval %h",
                          exp_tid, exp_data, exp_exv, exp_cause, exp_tval);
      act_str = $sformatf("tid %0d data %h ex %0b cause %0d tval %h",
                          res.trans_id, res.data, res.ex.valid, res.ex.cause, res.ex.tval);
      $display("FAILED %s: expected %s, got %s", name, exp_str, act_str);
      errors_o++;
    end else begin
      $display("PASSED %s", name);
      passed++;
    end
    grants = 0;
    idx++;
    if (idx == N_TESTS) begin
      $display("Tests run %0d, passed %0d, errors %0d", N_TESTS, passed, errors_o);
      done_o = 1'b1;
    end
  endtask

  // Registered outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (mem_req_i || !lsu_ready_i || load_res_i.valid || store_res_i.valid) begin
          $display("After reset the unit was not idle with ready high and no results");
          errors_o++;
        end
      end
      if (store_res_i.valid) begin
        check_result(store_res_i, 1'b1);
      end
      if (load_res_i.valid) begin
        check_result(load_res_i, 1'b0);
      end
      if (mem_req_i && mem_gnt_i) begin
        grants++;
      end
    end
  end

endmodule

/* bench/lsu_tb.sv */
// Testbench for the load/store unit with a byte-addressed memory model.
// Issues the operations from the patterns file, the checker judges results.

`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int N_TESTS    = 18;
  localparam int MAX_CYCLES = N_TESTS * 20;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         op_valid_i;
  lsu_req_t     op_i;
  logic         lsu_ready_o;
  logic         mem_req_o;
  logic         mem_we_o;
  xlen_t        mem_addr_o;
  be_t          mem_be_o;
  xlen_t        mem_wdata_o;
  logic         mem_gnt_i;
  logic         mem_rvalid_i;
  xlen_t        mem_rdata_i;
  lsu_result_t  load_res_o;
  lsu_result_t  store_res_o;
  logic [147:0] patterns [N_TESTS];
  logic [7:0]   mem [256];
  int unsigned  gnt_cnt;
  int unsigned  rd_cnt;
  logic         rd_pending;
  xlen_t        rd_addr;
  int           cycles = 0;
  logic         checks_done;
  int           errors;

  always #10 clk_i = ~clk_i;

  lsu_top lsu_top_inst (.*);

  lsu_checker #(.N_TESTS(N_TESTS)) lsu_checker_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .patterns_i (patterns),
    .load_res_i (load_res_o),
    .store_res_i(store_res_o),
    .lsu_ready_i(lsu_ready_o),
    .mem_req_i  (mem_req_o),
    .mem_gnt_i  (mem_gnt_i),
    .done_o     (checks_done),
    .errors_o   (errors)
  );

  function automatic xlen_t read_word(input xlen_t addr);
    logic [7:0] base;
    base = {addr[7:2], 2'b00};
    return {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
  endfunction

  // ----------------------------------------------------------------------
  // Memory model with random grant and read-valid delays
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    mem_gnt_i    <= 1'b0;
    mem_rvalid_i <= 1'b0;
    if (!rst_ni) begin
      rd_pending = 1'b0;
      gnt_cnt    = $urandom % 4;
    end else begin
      if (rd_pending) begin
        if (rd_cnt == 0) begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= read_word(rd_addr);
          rd_pending = 1'b0;
        end else begin
          rd_cnt--;
        end
      end
      if (mem_req_o && mem_gnt_i) begin
        if (mem_we_o) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_be_o[b]) begin
              mem[{mem_addr_o[7:2], 2'b00} + 8'(b)] = mem_wdata_o[8*b +: 8];
            end
          end
        end else begin
          rd_pending = 1'b1;
          rd_cnt     = $urandom % 4;
          rd_addr    = mem_addr_o;
        end
        gnt_cnt = $urandom % 4;
      end else if (mem_req_o) begin
        if (gnt_cnt == 0) begin
          mem_gnt_i <= 1'b1;
        end else begin
          gnt_cnt--;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus and end of run
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(32'h7a38));
    rst_ni       <= 1'b0;
    op_valid_i   <= 1'b0;
    op_i         <= '0;
    mem_gnt_i    <= 1'b0;
    mem_rvalid_i <= 1'b0;
    mem_rdata_i  <= '0;
    $readmemh("bench/lsu_patterns.hex", patterns);
    for (int n = 0; n < 256; n++) begin
      mem[n] = 8'(n) ^ 8'h5a;
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < N_TESTS; i++) begin
      op_valid_i         <= 1'b1;
      op_i.op            <= lsu_op_e'(patterns[i][147:144]);
      op_i.operand_a     <= patterns[i][143:112];
      op_i.imm           <= patterns[i][111:80];
      op_i.operand_b     <= patterns[i][79:48];
      op_i.trans_id      <= patterns[i][46:44];
      // Held until the unit reports ready in the cycle of the edge
      do @(posedge clk_i); while (!lsu_ready_o);
    end
    op_valid_i <= 1'b0;
    wait (checks_done === 1'b1);
    @(posedge clk_i);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: not all results arrived within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* bench/lsu_patterns.hex */
// op _ operand_a _ imm _ operand_b _ trans_id _ expected data _ expected ex valid _ cause
// Memory byte n starts as n ^ 5a, store results carry zero data
4_00000010_00000000_00000000_0_49484b4a_0_00
0_00000080_00000003_00000000_1_ffffffd9_0_00
1_00000080_00000003_00000000_2_000000d9_0_00
2_00000080_00000002_00000000_3_ffffd9d8_0_00
3_00000080_00000002_00000000_4_0000d9d8_0_00
0_00000024_fffffffc_00000000_5_0000007a_0_00
8_00000040_00000001_000000a5_6_00000000_0_00
4_00000040_00000000_00000000_7_1918a51a_0_00
9_00000050_00000002_0000beef_0_00000000_0_00
4_00000050_00000000_00000000_1_beef0b0a_0_00
a_00000060_00000000_cafef00d_2_00000000_0_00
4_00000060_00000000_00000000_3_cafef00d_0_00
2_00000031_00000000_00000000_4_00000000_1_04
4_00000030_00000002_00000000_5_00000000_1_04
9_00000071_00000000_0000abcd_6_00000000_1_06
a_00000070_00000001_12345678_7_00000000_1_06
4_00000070_00000000_00000000_0_29282b2a_0_00
1_00000052_00000000_00000000_1_000000ef_0_00

/* files.f */
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_agu.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_load_align.sv
logic/lsu_result_pipe.sv
logic/lsu_top.sv
bench/lsu_sva.sv
bench/lsu_checker.sv
bench/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= lsu_tb
FILELIST  ?= files.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
